// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_router_switch
FILELIST  ?= filelist.f

.PHONY: all lint sim clean

all: sim

# static checks only, no executable
lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and require the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: filelist.f
router_pkg.sv
rr_order_register.sv
rr_priority_select.sv
rr_port_arbiter.sv
switch_crossbar.sv
router_switch.sv
tb_router_switch.sv

// File: router_pkg.sv
`default_nettype none

package router_pkg;

  // number of router ports, one per mesh direction plus the local core
  localparam int NUM_PORTS = 5;

  // next-hop address width, wide enough for every port index
  localparam int ADDR_W = 3;

  // port index, also used as the next-hop address encoding
  // address values 5 to 7 name no port and are never routed
  typedef enum logic [ADDR_W-1:0] {
    PORT_NORTH = 3'd0,
    PORT_SOUTH = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_EAST  = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  // one bit per port, indexed by port_e
  // carries requests, grants, priority, valid and ready bits
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// File: router_switch.sv
`timescale 1ns/1ns
`default_nettype none

module router_switch #(
  parameter int FLIT_W = 16
) (
  input  logic                                                   clk,
  input  logic                                                   reset_i,
  input  router_pkg::port_mask_t                                 in_valid_i,
  input  logic [router_pkg::NUM_PORTS-1:0][router_pkg::ADDR_W-1:0] in_dest_i,
  input  logic [router_pkg::NUM_PORTS-1:0][FLIT_W-1:0]            in_data_i,
  output router_pkg::port_mask_t                                 in_ready_o,
  output router_pkg::port_mask_t                                 out_valid_o,
  output logic [router_pkg::NUM_PORTS-1:0][FLIT_W-1:0]            out_data_o
);

  import router_pkg::*;

  // one grant vector per output port
  port_mask_t grant_n;
  port_mask_t grant_s;
  port_mask_t grant_w;
  port_mask_t grant_e;
  port_mask_t grant_l;

  rr_port_arbiter #(
    .OUT_PORT (PORT_NORTH)
  ) arb_n (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_dest_i  (in_dest_i),
    .grant_o    (grant_n)
  );

  rr_port_arbiter #(
    .OUT_PORT (PORT_SOUTH)
  ) arb_s (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_dest_i  (in_dest_i),
    .grant_o    (grant_s)
  );

  rr_port_arbiter #(
    .OUT_PORT (PORT_WEST)
  ) arb_w (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_dest_i  (in_dest_i),
    .grant_o    (grant_w)
  );

  rr_port_arbiter #(
    .OUT_PORT (PORT_EAST)
  ) arb_e (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_dest_i  (in_dest_i),
    .grant_o    (grant_e)
  );

  rr_port_arbiter #(
    .OUT_PORT (PORT_LOCAL)
  ) arb_l (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (in_valid_i),
    .in_dest_i  (in_dest_i),
    .grant_o    (grant_l)
  );

  // data path and input ready
  switch_crossbar #(
    .FLIT_W (FLIT_W)
  ) i_switch_crossbar (
    .clk         (clk),
    .reset_i     (reset_i),
    .grant_n_i   (grant_n),
    .grant_s_i   (grant_s),
    .grant_w_i   (grant_w),
    .grant_e_i   (grant_e),
    .grant_l_i   (grant_l),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

`default_nettype wire

// File: rr_order_register.sv
`timescale 1ns/1ns
`default_nettype none

module rr_order_register (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   advance_i,
  input  router_pkg::port_e      winner_i,
  output router_pkg::port_mask_t priority_o
);

  import router_pkg::*;

  port_mask_t order_q;
  port_mask_t order_next;
  port_mask_t winner_oh;

  // next pointer is the port after the winner
  always_comb begin
    winner_oh  = port_mask_t'(1) << winner_i;
    order_next = order_q;
    if (advance_i) begin
      // rotate left by one, local wraps back to north
      order_next = {winner_oh[NUM_PORTS-2:0], winner_oh[NUM_PORTS-1]};
    end
  end

  // north holds top priority out of reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      order_q <= port_mask_t'(1);
    end else begin
      order_q <= order_next;
    end
  end

  assign priority_o = order_q;

  // pointer stays one-hot across every update
  a_priority_onehot: assert property (
    @(posedge clk) disable iff (reset_i)
    $onehot(order_q)
  );

  // the select logic only reports real ports
  a_winner_in_range: assert property (
    @(posedge clk) disable iff (reset_i)
    advance_i |-> (winner_i < NUM_PORTS)
  );

endmodule

`default_nettype wire

// File: rr_port_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_port_arbiter #(
  parameter router_pkg::port_e OUT_PORT = router_pkg::PORT_NORTH
) (
  input  logic                                                   clk,
  input  logic                                                   reset_i,
  input  router_pkg::port_mask_t                                 in_valid_i,
  input  logic [router_pkg::NUM_PORTS-1:0][router_pkg::ADDR_W-1:0] in_dest_i,
  output router_pkg::port_mask_t                                 grant_o
);

  import router_pkg::*;

  port_mask_t request;
  port_mask_t priority_vec;
  port_mask_t grant;
  port_e      winner;
  logic       grant_valid;

  // input p wants this output when its next hop names it
  always_comb begin
    request = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      // no u-turns, an input never routes back out of its own port
      request[p] = in_valid_i[p]
                 && (in_dest_i[p] == OUT_PORT)
                 && (p != int'(OUT_PORT));
    end
  end

  // rotating priority pointer
  rr_order_register i_order_register (
    .clk        (clk),
    .reset_i    (reset_i),
    .advance_i  (grant_valid),
    .winner_i   (winner),
    .priority_o (priority_vec)
  );

  // pick one requester starting at the pointer
  rr_priority_select i_priority_select (
    .request_i     (request),
    .priority_i    (priority_vec),
    .grant_o       (grant),
    .winner_o      (winner),
    .grant_valid_o (grant_valid)
  );

  assign grant_o = grant;

  // grants only go to inputs that asked for this port
  a_grant_requested: assert property (
    @(posedge clk) disable iff (reset_i)
    (grant & ~request) == '0
  );

  // at most one winner per output
  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (reset_i)
    $onehot0(grant)
  );

  // a request always produces a grant
  a_request_served: assert property (
    @(posedge clk) disable iff (reset_i)
    (request != '0) |-> $onehot(grant)
  );

endmodule

`default_nettype wire

// File: rr_priority_select.sv
`timescale 1ns/1ns
`default_nettype none

module rr_priority_select (
  input  router_pkg::port_mask_t request_i,
  input  router_pkg::port_mask_t priority_i,
  output router_pkg::port_mask_t grant_o,
  output router_pkg::port_e      winner_o,
  output logic                   grant_valid_o
);

  import router_pkg::*;

  port_mask_t upper_mask;
  port_mask_t req_upper;
  port_mask_t req_pick;
  port_mask_t grant_oh;

  always_comb begin
    // ports at or above the pointer bit
    upper_mask = ~(priority_i - port_mask_t'(1));
    req_upper  = request_i & upper_mask;

    // nothing at or above the pointer, so wrap to the low ports
    if (req_upper != '0) begin
      req_pick = req_upper;
    end else begin
      req_pick = request_i;
    end

    // lowest remaining request wins
    grant_oh = req_pick & (~req_pick + port_mask_t'(1));
  end

  // index of the winner, for the pointer update
  always_comb begin
    winner_o = PORT_NORTH;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant_oh[i]) begin
        winner_o = port_e'(i);
      end
    end
  end

  assign grant_o       = grant_oh;
  assign grant_valid_o = |request_i;

endmodule

`default_nettype wire

// File: switch_crossbar.sv
`timescale 1ns/1ns
`default_nettype none

module switch_crossbar #(
  parameter int FLIT_W = 16
) (
  input  logic                                        clk,
  input  logic                                        reset_i,
  input  router_pkg::port_mask_t                      grant_n_i,
  input  router_pkg::port_mask_t                      grant_s_i,
  input  router_pkg::port_mask_t                      grant_w_i,
  input  router_pkg::port_mask_t                      grant_e_i,
  input  router_pkg::port_mask_t                      grant_l_i,
  input  logic [router_pkg::NUM_PORTS-1:0][FLIT_W-1:0] in_data_i,
  output router_pkg::port_mask_t                      in_ready_o,
  output router_pkg::port_mask_t                      out_valid_o,
  output logic [router_pkg::NUM_PORTS-1:0][FLIT_W-1:0] out_data_o
);

  import router_pkg::*;

  // grant vector of each output, indexed by output port
  port_mask_t grant [NUM_PORTS];

  port_mask_t                       ready;
  port_mask_t                       overlap;
  port_mask_t                       out_grant;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] sel_data;
  port_mask_t                       out_valid_q;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] out_data_q;

  assign grant[PORT_NORTH] = grant_n_i;
  assign grant[PORT_SOUTH] = grant_s_i;
  assign grant[PORT_WEST]  = grant_w_i;
  assign grant[PORT_EAST]  = grant_e_i;
  assign grant[PORT_LOCAL] = grant_l_i;

  always_comb begin
    sel_data  = '0;
    ready     = '0;
    overlap   = '0;
    out_grant = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      // and-or mux, grant is one-hot or zero
      for (int p = 0; p < NUM_PORTS; p++) begin
        sel_data[k] = sel_data[k] | (in_data_i[p] & {FLIT_W{grant[k][p]}});
      end
      out_grant[k] = |grant[k];
      // an input already granted elsewhere shows up here
      overlap = overlap | (ready & grant[k]);
      ready   = ready | grant[k];
    end
  end

  // flits leave one cycle after the transfer
  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_q <= '0;
      out_data_q  <= '0;
    end else begin
      out_valid_q <= out_grant;
      for (int k = 0; k < NUM_PORTS; k++) begin
        if (out_grant[k]) begin
          out_data_q[k] <= sel_data[k];
        end
      end
    end
  end

  assign in_ready_o  = ready;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  // each input has one destination, so two arbiters never pick it together
  a_single_output: assert property (
    @(posedge clk) disable iff (reset_i)
    overlap == '0
  );

endmodule

`default_nettype wire

// File: tb_router_switch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_router_switch;

  import router_pkg::*;

  localparam int FLIT_W        = 16;
  localparam int RAND_ROWS     = 40;
  localparam int RESET_TIMEOUT = 20;

  logic                             clk;
  logic                             reset_i;
  port_mask_t                       in_valid_i;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] in_dest_i;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] in_data_i;
  port_mask_t                       in_ready_o;
  port_mask_t                       out_valid_o;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] out_data_o;

  // stimulus table with one entry per cycle
  port_mask_t                       row_valid [$];
  logic [NUM_PORTS-1:0][ADDR_W-1:0] row_dest [$];
  logic [NUM_PORTS-1:0][FLIT_W-1:0] row_data [$];

  // reference model state
  int                               ptr [NUM_PORTS];
  port_mask_t                       exp_ready;
  port_mask_t                       exp_valid;
  logic [NUM_PORTS-1:0][FLIT_W-1:0] exp_data;

  logic [31:0] lcg_state;

  router_switch #(
    .FLIT_W (FLIT_W)
  ) i_router_switch (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_dest_i   (in_dest_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  // reset for three rising edges
  initial begin
    reset_i = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset_i = 1'b0;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // data words are derived from a per-row base
  task automatic add_row(input port_mask_t valid, input logic [ADDR_W-1:0] dn,
                         input logic [ADDR_W-1:0] ds, input logic [ADDR_W-1:0] dw,
                         input logic [ADDR_W-1:0] de, input logic [ADDR_W-1:0] dl,
                         input logic [FLIT_W-1:0] base);
    logic [NUM_PORTS-1:0][FLIT_W-1:0] data;
    for (int p = 0; p < NUM_PORTS; p++) begin
      data[p] = base ^ FLIT_W'(p * 32'h1111);
    end
    row_valid.push_back(valid);
    row_dest.push_back({dl, de, dw, ds, dn});
    row_data.push_back(data);
  endtask

  task automatic build_table();
    port_mask_t                       valid;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] dest;
    logic [NUM_PORTS-1:0][FLIT_W-1:0] data;
    // idle after reset
    add_row(5'b00000, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 16'h0000);
    add_row(5'b00000, 3'd1, 3'd2, 3'd3, 3'd4, 3'd0, 16'h0bad);
    // south alone to north and an idle row to see it leave
    add_row(5'b00010, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 16'h1230);
    add_row(5'b00000, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 16'h0000);
    // north, south, west and east all want local
    for (int r = 0; r < 6; r++) begin
      add_row(5'b01111, 3'd4, 3'd4, 3'd4, 3'd4, 3'd0, FLIT_W'(16'h4000 + r * 16));
    end
    // south, west, east and local all want north
    for (int r = 0; r < 5; r++) begin
      add_row(5'b11110, 3'd1, 3'd0, 3'd0, 3'd0, 3'd0, FLIT_W'(16'h5000 + r * 16));
    end
    // every input to a different output
    add_row(5'b11111, 3'd1, 3'd4, 3'd3, 3'd0, 3'd2, 16'h6a00);
    add_row(5'b11111, 3'd3, 3'd2, 3'd4, 3'd1, 3'd0, 16'h6b00);
    // u-turns and unused addresses
    add_row(5'b11111, 3'd0, 3'd5, 3'd2, 3'd7, 3'd6, 16'h7c00);
    add_row(5'b00111, 3'd0, 3'd0, 3'd5, 3'd0, 3'd0, 16'h7d00);
    add_row(5'b00000, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 16'h0000);
    // random rows skip the weak low generator bits
    for (int r = 0; r < RAND_ROWS; r++) begin
      lcg_state = lcg_next(lcg_state);
      valid = lcg_state[28:24];
      for (int p = 0; p < NUM_PORTS; p++) begin
        lcg_state = lcg_next(lcg_state);
        dest[p] = lcg_state[31:29];
        data[p] = lcg_state[23:8];
      end
      row_valid.push_back(valid);
      row_dest.push_back(dest);
      row_data.push_back(data);
    end
  endtask

  // round-robin model called once per transfer cycle
  task automatic predict(input port_mask_t valid,
                         input logic [NUM_PORTS-1:0][ADDR_W-1:0] dest,
                         input logic [NUM_PORTS-1:0][FLIT_W-1:0] data);
    int   start;
    int   p;
    logic found;
    exp_ready = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      start        = ptr[k];
      found        = 1'b0;
      exp_valid[k] = 1'b0;
      for (int j = 0; j < NUM_PORTS; j++) begin
        p = (start + j) % NUM_PORTS;
        if (!found && valid[p] && int'(dest[p]) == k && p != k) begin
          found        = 1'b1;
          exp_ready[p] = 1'b1;
          exp_valid[k] = 1'b1;
          exp_data[k]  = data[p];
          ptr[k]       = (p + 1) % NUM_PORTS;
        end
      end
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t expected,
                            input port_mask_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_flit(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_mask("out_valid_o", exp_valid, out_valid_o);
    for (int k = 0; k < NUM_PORTS; k++) begin
      check_flit($sformatf("out_data_o[%0d]", k), exp_data[k], out_data_o[k]);
    end
  endtask

  initial begin
    int wait_cycles;
    in_valid_i  = '0;
    in_dest_i   = '0;
    in_data_i   = '0;
    lcg_state   = 32'h545ac387;
    exp_ready   = '0;
    exp_valid   = '0;
    exp_data    = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      ptr[k] = 0;
    end
    build_table();

    wait_cycles = 0;
    while (reset_i !== 1'b0) begin
      @(posedge clk);
      #3;
      wait_cycles++;
      if (wait_cycles > RESET_TIMEOUT) begin
        $display("reset was never released");
        $display("test failed");
        $fatal(1, "reset timeout");
      end
    end

    // outputs clear and nothing ready while idle
    check_mask("out_valid_o", '0, out_valid_o);
    check_mask("in_ready_o", '0, in_ready_o);

    for (int i = 0; i < row_valid.size(); i++) begin
      @(posedge clk);
      #2;
      check_outputs();
      in_valid_i = row_valid[i];
      in_dest_i  = row_dest[i];
      in_data_i  = row_data[i];
      #1;
      predict(row_valid[i], row_dest[i], row_data[i]);
      check_mask("in_ready_o", exp_ready, in_ready_o);
    end

    // last transfer leaves one cycle later
    @(posedge clk);
    #2;
    check_outputs();
    in_valid_i = '0;

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
